//--- chipset.f
src/bus_pkg.sv
src/map_pkg.sv
src/addr_decode.sv
src/system_ram.sv
src/kbd_fifo.sv
src/segment_display.sv
src/read_return.sv
src/chipset.sv
bench/chipset_checker.sv
bench/chipset_tb.sv

//--- Makefile
# Verilator simulation of the chipset testbench

VERILATOR ?= verilator
TOP       ?= chipset_tb
FILELIST  ?= chipset.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	set -o pipefail; ./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/chipset_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chipset_tb;

    localparam int NUM_CYCLES    = 4000;
    localparam int STARVE_LIMIT  = 300;
    localparam int DRAIN_TIMEOUT = 500;

    logic                cpu_clk;
    logic                reset_async;
    bus_pkg::dmem_req_t  dmem_req;
    logic [15:0]         switch_bank;
    bus_pkg::kbd_event_t kbd_event;
    bus_pkg::word_t      dmem_rsp;
    logic                kbd_credit;
    logic                kbd_interrupt;
    logic [7:0]          dsp_anode;
    logic [7:0]          dsp_cathode;
    int                  checker_errors;

    logic [31:0]         lfsr_q;
    int                  credits;
    int                  starve_cnt;
    int                  bench_errors;
    int                  timer;
    logic                timeout_hit;

    chipset UUT (
        .cpu_clk_i       (cpu_clk),
        .reset_async_i   (reset_async),
        .dmem_req_i      (dmem_req),
        .switch_i        (switch_bank),
        .kbd_event_i     (kbd_event),
        .dmem_rsp_o      (dmem_rsp),
        .kbd_credit_o    (kbd_credit),
        .kbd_interrupt_o (kbd_interrupt),
        .dsp_anode_o     (dsp_anode),
        .dsp_cathode_o   (dsp_cathode)
    );

    chipset_checker scoreboard (
        .cpu_clk_i       (cpu_clk),
        .reset_async_i   (reset_async),
        .dmem_req_i      (dmem_req),
        .switch_i        (switch_bank),
        .kbd_event_i     (kbd_event),
        .dmem_rsp_i      (dmem_rsp),
        .kbd_credit_i    (kbd_credit),
        .kbd_interrupt_i (kbd_interrupt),
        .dsp_anode_i     (dsp_anode),
        .dsp_cathode_i   (dsp_cathode),
        .errors_o        (checker_errors)
    );

    initial begin
        cpu_clk = 1'b0;
        forever begin
            #20 cpu_clk = ~cpu_clk;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Next falling edge, picking up any returned credit
    task automatic step_cycle();
        @(negedge cpu_clk);
        if (kbd_credit === 1'b1) begin
            credits++;
        end
    endtask

    task automatic drive_random_request();
        logic [2:0] kind;
        logic [3:0] alias_bits;
        logic [2:0] word_sel;
        kind       = 3'(rand_bits(3));
        alias_bits = 4'(rand_bits(4));
        word_sel   = 3'(rand_bits(3));
        case (kind)
            3'd4: dmem_req.addr = map_pkg::DSP_ADDR;
            3'd5: dmem_req.addr = map_pkg::SW_ADDR;
            3'd6: dmem_req.addr = map_pkg::KBD_ADDR;
            3'd7: begin
                case (word_sel[1:0])
                    2'd0:    dmem_req.addr = 32'hFF00_000C;
                    2'd1:    dmem_req.addr = {4'h2, 23'h0, word_sel, 2'b00};
                    2'd2:    dmem_req.addr = 32'hFF00_0001;
                    default: dmem_req.addr = 32'h0000_0004;
                endcase
            end
            // Eight RAM words, upper bits vary to exercise aliasing
            default: dmem_req.addr = {4'h1, 8'h00, alias_bits, 11'h000, word_sel, 2'b00};
        endcase
        if (rand_bits(1) == 1) begin
            dmem_req.rd    = 1'b0;
            dmem_req.wmask = 4'(rand_bits(4));
            dmem_req.wdata = rand_bits(32);
        end else begin
            dmem_req.rd    = 1'b1;
            dmem_req.wmask = 4'b0000;
            dmem_req.wdata = '0;
        end
        if (rand_bits(4) == 0) begin
            switch_bank = 16'(rand_bits(16));
        end
    endtask

    task automatic drive_keyboard();
        kbd_event = '0;
        if (credits > 0) begin
            starve_cnt = 0;
            if (rand_bits(2) != 0) begin
                kbd_event.valid = 1'b1;
                kbd_event.code  = 8'(rand_bits(8));
                credits--;
            end
        end else begin
            starve_cnt++;
            if (starve_cnt == STARVE_LIMIT) begin
                $display("Keyboard producer waited %0d cycles without a credit", STARVE_LIMIT);
                bench_errors++;
            end
        end
    endtask

    initial begin
        reset_async  = 1'b1;
        dmem_req     = '0;
        switch_bank  = 16'h0000;
        kbd_event    = '0;
        lfsr_q       = 32'h2265;
        credits      = 0;
        starve_cnt   = 0;
        bench_errors = 0;
        timeout_hit  = 1'b0;

        repeat (3) @(posedge cpu_clk);
        @(negedge cpu_clk);
        reset_async = 1'b0;
        repeat (bus_pkg::RESET_CYCLES + 2) step_cycle();
        credits = bus_pkg::KBD_DEPTH;

        repeat (NUM_CYCLES) begin
            step_cycle();
            drive_random_request();
            drive_keyboard();
        end

        // Let the last request and key event reach the UUT
        step_cycle();
        dmem_req  = '0;
        kbd_event = '0;

        // Drain the FIFO with keyboard reads
        timer = 0;
        while ((kbd_interrupt !== 1'b0) && (timer < DRAIN_TIMEOUT)) begin
            step_cycle();
            dmem_req      = '0;
            dmem_req.addr = map_pkg::KBD_ADDR;
            dmem_req.rd   = 1'b1;
            timer++;
        end
        if (timer >= DRAIN_TIMEOUT) begin
            $display("Keyboard FIFO did not drain before the timeout");
            timeout_hit = 1'b1;
        end

        // Last credit arrives a cycle after the last pop
        timer = 0;
        while ((credits != bus_pkg::KBD_DEPTH) && (timer < DRAIN_TIMEOUT)) begin
            step_cycle();
            dmem_req = '0;
            timer++;
        end
        if (timer >= DRAIN_TIMEOUT) begin
            $display("Keyboard credits did not return before the timeout");
            timeout_hit = 1'b1;
        end
        if (credits != bus_pkg::KBD_DEPTH) begin
            $display("CHECK FAILED final_credits: expected %0d, actual %0d",
                     bus_pkg::KBD_DEPTH, credits);
            bench_errors++;
        end

        dmem_req = '0;
        repeat (2) step_cycle();

        $display("Errors: checker %0d, bench %0d", checker_errors, bench_errors);
        if (timeout_hit || (checker_errors != 0) || (bench_errors != 0)) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/chipset_checker.sv
`timescale 1ns/1ps
`default_nettype none

module chipset_checker (
    input  wire logic                cpu_clk_i,
    input  wire logic                reset_async_i,
    input  wire bus_pkg::dmem_req_t  dmem_req_i,
    input  wire logic [15:0]         switch_i,
    input  wire bus_pkg::kbd_event_t kbd_event_i,
    input  wire bus_pkg::word_t      dmem_rsp_i,
    input  wire logic                kbd_credit_i,
    input  wire logic                kbd_interrupt_i,
    input  wire logic [7:0]          dsp_anode_i,
    input  wire logic [7:0]          dsp_cathode_i,
    output int                       errors_o
);

    // Internal reset model, stretched RESET_CYCLES+1 edges past the release
    logic           rst_known;
    logic           rst_int;
    int             rst_cnt;
    logic           armed;

    bus_pkg::word_t ram_model [bus_pkg::RAM_WORDS];
    logic [3:0]     ram_valid [bus_pkg::RAM_WORDS];
    bus_pkg::word_t dsp_model;
    logic [7:0]     kbd_queue [$];

    logic           scan_on;
    int             div_cnt;
    logic [2:0]     digit;

    // What the ports should show after the last edge
    logic           rsp_pending;
    bus_pkg::word_t exp_rsp;
    bus_pkg::word_t rsp_mask;
    string          rsp_name;
    logic           exp_credit;
    logic           exp_int;
    logic [7:0]     exp_anode;
    logic [7:0]     exp_cathode;
    int             pops;
    int             credits_seen;

    initial begin
        rst_known    = 1'b0;
        rst_int      = 1'b0;
        rst_cnt      = 0;
        armed        = 1'b0;
        errors_o     = 0;
        pops         = 0;
        credits_seen = 0;
        for (int i = 0; i < bus_pkg::RAM_WORDS; i++) begin
            ram_valid[i] = 4'b0000;
        end
    end

    function automatic bus_pkg::region_t region_of(input bus_pkg::word_t addr);
        if (addr[31:28] == map_pkg::RAM_NIBBLE) begin
            return bus_pkg::REGION_RAM;
        end else if (addr == map_pkg::DSP_ADDR) begin
            return bus_pkg::REGION_DISPLAY;
        end else if (addr == map_pkg::SW_ADDR) begin
            return bus_pkg::REGION_SWITCH;
        end else if (addr == map_pkg::KBD_ADDR) begin
            return bus_pkg::REGION_KEYBOARD;
        end
        return bus_pkg::REGION_NONE;
    endfunction

    function automatic bus_pkg::word_t byte_mask(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic flag_mismatch(input string name, input bus_pkg::word_t exp,
                                 input bus_pkg::word_t act);
        $display("CHECK FAILED %s: expected %08h, actual %08h at %0t", name, exp, act, $time);
        errors_o++;
    endtask

    task automatic protocol_error(input string what);
        $display("Protocol problem at %0t: %s", $time, what);
        errors_o++;
    endtask

    task automatic check_outputs();
        // Unwritten RAM bytes are masked out
        if (rsp_pending && ((dmem_rsp_i & rsp_mask) !== (exp_rsp & rsp_mask))) begin
            flag_mismatch(rsp_name, exp_rsp, dmem_rsp_i);
        end
        if (kbd_credit_i !== exp_credit) begin
            flag_mismatch("kbd_credit", 32'(exp_credit), 32'(kbd_credit_i));
        end
        if (kbd_interrupt_i !== exp_int) begin
            flag_mismatch("kbd_interrupt", 32'(exp_int), 32'(kbd_interrupt_i));
        end
        if (dsp_anode_i !== exp_anode) begin
            flag_mismatch("display_anode", 32'(exp_anode), 32'(dsp_anode_i));
        end
        if (dsp_cathode_i !== exp_cathode) begin
            flag_mismatch("display_cathode", 32'(exp_cathode), 32'(dsp_cathode_i));
        end
        if (scan_on && ($countones(~dsp_anode_i) != 1)) begin
            protocol_error("display does not have exactly one anode low");
        end
        if (kbd_credit_i === 1'b1) begin
            credits_seen++;
        end
        if (credits_seen > pops) begin
            protocol_error("more keyboard credits returned than events popped");
        end
    endtask

    task automatic reset_model();
        kbd_queue.delete();
        dsp_model   = '0;
        scan_on     = 1'b0;
        div_cnt     = 0;
        digit       = 3'd0;
        rsp_pending = 1'b0;
        exp_credit  = 1'b0;
        exp_int     = 1'b0;
        exp_anode   = 8'hFF;
        exp_cathode = 8'hFF;
        armed       = 1'b1;
    endtask

    task automatic step_model();
        bus_pkg::region_t region;
        bus_pkg::word_t   old_dsp;
        int               idx;
        int               fill;
        region      = region_of(dmem_req_i.addr);
        idx         = int'(dmem_req_i.addr[11:2]);
        fill        = kbd_queue.size();
        old_dsp     = dsp_model;
        rsp_pending = dmem_req_i.rd;
        rsp_mask    = '1;

        // Response word as seen before this edge's updates
        case (region)
            bus_pkg::REGION_RAM: begin
                exp_rsp  = ram_model[idx];
                rsp_mask = byte_mask(ram_valid[idx]);
                rsp_name = "ram_read";
            end
            bus_pkg::REGION_DISPLAY: begin
                exp_rsp  = dsp_model;
                rsp_name = "display_read";
            end
            bus_pkg::REGION_SWITCH: begin
                exp_rsp  = {16'h0000, switch_i};
                rsp_name = "switch_read";
            end
            bus_pkg::REGION_KEYBOARD: begin
                exp_rsp  = (fill > 0) ? (32'h0001_0000 | {24'h0, kbd_queue[0]}) : '0;
                rsp_name = "keyboard_read";
            end
            default: begin
                exp_rsp  = '0;
                rsp_name = "unmapped_read";
            end
        endcase

        // New digit each period, showing the value held before this edge
        if (!scan_on || (div_cnt == map_pkg::DSP_DIVISOR - 1)) begin
            digit       = scan_on ? digit + 3'd1 : 3'd0;
            scan_on     = 1'b1;
            div_cnt     = 0;
            exp_anode   = ~(8'h01 << digit);
            exp_cathode = map_pkg::SEG_CODES[old_dsp[4*digit +: 4]];
        end else begin
            div_cnt++;
        end

        for (int i = 0; i < 4; i++) begin
            if (dmem_req_i.wmask[i]) begin
                if (region == bus_pkg::REGION_RAM) begin
                    ram_model[idx][8*i +: 8] = dmem_req_i.wdata[8*i +: 8];
                    ram_valid[idx][i]        = 1'b1;
                end else if (region == bus_pkg::REGION_DISPLAY) begin
                    dsp_model[8*i +: 8] = dmem_req_i.wdata[8*i +: 8];
                end
            end
        end

        exp_credit = 1'b0;
        if ((region == bus_pkg::REGION_KEYBOARD) && dmem_req_i.rd && (fill > 0)) begin
            void'(kbd_queue.pop_front());
            pops++;
            exp_credit = 1'b1;
        end
        if (kbd_event_i.valid) begin
            if (fill == bus_pkg::KBD_DEPTH) begin
                protocol_error("keyboard event pushed while the FIFO was full");
            end else begin
                kbd_queue.push_back(kbd_event_i.code);
            end
        end
        exp_int = (kbd_queue.size() > 0);
    endtask

    // Ports still hold pre-edge values here, inputs settled at the falling edge
    always @(posedge cpu_clk_i) begin
        if (armed) begin
            check_outputs();
        end
        if (rst_known) begin
            if (rst_int) begin
                reset_model();
            end else begin
                step_model();
            end
        end
        if (reset_async_i === 1'b1) begin
            rst_known = 1'b1;
            rst_int   = 1'b1;
            rst_cnt   = 0;
        end else if (rst_known) begin
            rst_cnt++;
            rst_int = (rst_cnt <= bus_pkg::RESET_CYCLES);
        end
    end

endmodule

`default_nettype wire

//--- src/chipset.sv
`timescale 1ns/1ps
`default_nettype none

module chipset (
    input  wire logic                cpu_clk_i,
    input  wire logic                reset_async_i,
    input  wire bus_pkg::dmem_req_t  dmem_req_i,
    input  wire logic [15:0]         switch_i,
    input  wire bus_pkg::kbd_event_t kbd_event_i,
    output bus_pkg::word_t           dmem_rsp_o,
    output logic                     kbd_credit_o,
    output logic                     kbd_interrupt_o,
    output logic [7:0]               dsp_anode_o,
    output logic [7:0]               dsp_cathode_o
);

    logic                             rst_r;
    logic [bus_pkg::RESET_CYCLES-1:0] rst_chain_r;

    // Filled with ones while held, then drained one zero per cycle
    always_ff @(posedge cpu_clk_i) begin
        if (reset_async_i) begin
            {rst_r, rst_chain_r} <= '1;
        end else begin
            {rst_r, rst_chain_r} <= {rst_chain_r, 1'b0};
        end
    end

    bus_pkg::dmem_req_t req_w;
    bus_pkg::region_t   region_w;
    logic [3:0]         ram_wmask_w;
    logic [3:0]         dsp_wmask_w;
    logic               kbd_pop_w;
    bus_pkg::word_t     ram_rdata_w;
    bus_pkg::word_t     dsp_rdata_w;
    bus_pkg::word_t     kbd_rdata_w;

    // Accesses during the reset window are dropped
    assign req_w = rst_r ? '0 : dmem_req_i;

    addr_decode decode (
        .req_i       (req_w),
        .region_o    (region_w),
        .ram_wmask_o (ram_wmask_w),
        .dsp_wmask_o (dsp_wmask_w),
        .kbd_pop_o   (kbd_pop_w)
    );

    system_ram ram (
        .cpu_clk_i (cpu_clk_i),
        .addr_i    (req_w.addr),
        .wdata_i   (req_w.wdata),
        .wmask_i   (ram_wmask_w),
        .rdata_o   (ram_rdata_w)
    );

    kbd_fifo kbd (
        .cpu_clk_i   (cpu_clk_i),
        .reset_i     (rst_r),
        .event_i     (kbd_event_i),
        .pop_i       (kbd_pop_w),
        .credit_o    (kbd_credit_o),
        .rdata_o     (kbd_rdata_w),
        .interrupt_o (kbd_interrupt_o)
    );

    segment_display disp (
        .cpu_clk_i (cpu_clk_i),
        .reset_i   (rst_r),
        .wdata_i   (req_w.wdata),
        .wmask_i   (dsp_wmask_w),
        .rdata_o   (dsp_rdata_w),
        .anode_o   (dsp_anode_o),
        .cathode_o (dsp_cathode_o)
    );

    read_return ret (
        .cpu_clk_i   (cpu_clk_i),
        .reset_i     (rst_r),
        .region_i    (region_w),
        .switch_i    (switch_i),
        .ram_rdata_i (ram_rdata_w),
        .dsp_rdata_i (dsp_rdata_w),
        .kbd_rdata_i (kbd_rdata_w),
        .rsp_o       (dmem_rsp_o)
    );

endmodule

`default_nettype wire

//--- src/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  wire logic             cpu_clk_i,
    input  wire logic             reset_i,
    input  wire bus_pkg::region_t region_i,
    input  wire logic [15:0]      switch_i,
    input  wire bus_pkg::word_t   ram_rdata_i,
    input  wire bus_pkg::word_t   dsp_rdata_i,
    input  wire bus_pkg::word_t   kbd_rdata_i,
    output bus_pkg::word_t        rsp_o
);

    bus_pkg::region_t region_r;
    logic [15:0]      switch_r;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            region_r <= bus_pkg::REGION_NONE;
        end else begin
            region_r <= region_i;
        end
    end

    // Switches as seen during the request cycle
    always_ff @(posedge cpu_clk_i) begin
        switch_r <= switch_i;
    end

    always_comb begin
        case (region_r)
            bus_pkg::REGION_RAM:      rsp_o = ram_rdata_i;
            bus_pkg::REGION_DISPLAY:  rsp_o = dsp_rdata_i;
            bus_pkg::REGION_SWITCH:   rsp_o = {16'h0000, switch_r};
            bus_pkg::REGION_KEYBOARD: rsp_o = kbd_rdata_i;
            default:                  rsp_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/segment_display.sv
`timescale 1ns/1ps
`default_nettype none

module segment_display (
    input  wire logic           cpu_clk_i,
    input  wire logic           reset_i,
    input  wire bus_pkg::word_t wdata_i,
    input  wire logic [3:0]     wmask_i,
    output bus_pkg::word_t      rdata_o,
    output logic [7:0]          anode_o,
    output logic [7:0]          cathode_o
);

    bus_pkg::word_t                  value_r;
    logic [map_pkg::DSP_DIV_W-1:0]   div_r;
    logic [2:0]                      digit_r;
    logic                            scan_on_r;
    logic [2:0]                      digit_nx_w;
    logic                            load_w;

    // First load after reset starts at digit 0
    assign digit_nx_w = scan_on_r ? digit_r + 3'd1 : 3'd0;
    assign load_w     = !scan_on_r || (div_r == map_pkg::DSP_LAST);

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            value_r   <= '0;
            div_r     <= '0;
            digit_r   <= 3'd0;
            scan_on_r <= 1'b0;
            anode_o   <= 8'hFF;
            cathode_o <= map_pkg::SEG_OFF;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wmask_i[i]) begin
                    value_r[8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end

            // Digit pattern is latched once per period
            if (load_w) begin
                div_r     <= '0;
                digit_r   <= digit_nx_w;
                scan_on_r <= 1'b1;
                anode_o   <= ~(8'h01 << digit_nx_w);
                cathode_o <= map_pkg::SEG_CODES[value_r[4*digit_nx_w +: 4]];
            end else begin
                div_r <= div_r + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        rdata_o <= value_r;
    end

    // Exactly one digit lit once the scan is running
    a_one_anode: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        scan_on_r |-> $onehot(~anode_o))
    else $error("display anodes not one-hot low");

endmodule

`default_nettype wire

//--- src/kbd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_fifo (
    input  wire logic                cpu_clk_i,
    input  wire logic                reset_i,
    input  wire bus_pkg::kbd_event_t event_i,
    input  wire logic                pop_i,
    output logic                     credit_o,
    output bus_pkg::word_t           rdata_o,
    output logic                     interrupt_o
);

    logic [7:0]                    mem_r [bus_pkg::KBD_DEPTH];
    logic [bus_pkg::KBD_PTR_W-1:0] rd_ptr_r;
    logic [bus_pkg::KBD_PTR_W-1:0] wr_ptr_r;
    logic [bus_pkg::KBD_CNT_W-1:0] count_r;
    logic                          empty_w;
    logic                          push_w;
    logic                          pop_w;

    assign empty_w = (count_r == '0);
    assign push_w  = event_i.valid && (count_r != bus_pkg::KBD_FULL);
    assign pop_w   = pop_i && !empty_w;

    // Pending events raise the interrupt
    assign interrupt_o = !empty_w;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            rd_ptr_r <= '0;
            wr_ptr_r <= '0;
            count_r  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_w) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop_w) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({push_w, pop_w})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            // One credit back per event taken
            credit_o <= pop_w;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (push_w) begin
            mem_r[wr_ptr_r] <= event_i.code;
        end
    end

    // Valid flag at bit 16, code in the low byte
    always_ff @(posedge cpu_clk_i) begin
        if (empty_w) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= {15'b0, 1'b1, 8'b0, mem_r[rd_ptr_r]};
        end
    end

    // Producer must hold a credit before pushing
    a_no_push_full: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        event_i.valid |-> (count_r != bus_pkg::KBD_FULL))
    else $error("keyboard event pushed into a full FIFO");

    a_count_bound: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        count_r <= bus_pkg::KBD_FULL)
    else $error("keyboard FIFO count above depth");

endmodule

`default_nettype wire

//--- src/system_ram.sv
`timescale 1ns/1ps
`default_nettype none

module system_ram (
    input  wire logic           cpu_clk_i,
    input  wire bus_pkg::word_t addr_i,
    input  wire bus_pkg::word_t wdata_i,
    input  wire logic [3:0]     wmask_i,
    output bus_pkg::word_t      rdata_o
);

    bus_pkg::word_t                 mem_r [bus_pkg::RAM_WORDS];
    logic [bus_pkg::RAM_ADDR_W-1:0] index_w;

    // Word index, upper address bits alias
    assign index_w = addr_i[bus_pkg::RAM_ADDR_W+1:2];

    // Read every cycle, old contents win on a same-address write
    always_ff @(posedge cpu_clk_i) begin
        rdata_o <= mem_r[index_w];
    end

    always_ff @(posedge cpu_clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (wmask_i[i]) begin
                mem_r[index_w][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
    input  wire bus_pkg::dmem_req_t req_i,
    output bus_pkg::region_t        region_o,
    output logic [3:0]              ram_wmask_o,
    output logic [3:0]              dsp_wmask_o,
    output logic                    kbd_pop_o
);

    logic ram_hit_w;

    // RAM claims the whole top nibble, aliases included
    assign ram_hit_w = (req_i.addr[31:28] == map_pkg::RAM_NIBBLE);

    always_comb begin
        if (ram_hit_w) begin
            region_o = bus_pkg::REGION_RAM;
        end else if (req_i.addr == map_pkg::DSP_ADDR) begin
            region_o = bus_pkg::REGION_DISPLAY;
        end else if (req_i.addr == map_pkg::SW_ADDR) begin
            region_o = bus_pkg::REGION_SWITCH;
        end else if (req_i.addr == map_pkg::KBD_ADDR) begin
            region_o = bus_pkg::REGION_KEYBOARD;
        end else begin
            region_o = bus_pkg::REGION_NONE;
        end
    end

    // Only the selected device sees the byte mask
    // Switch and keyboard writes go nowhere
    assign ram_wmask_o = (region_o == bus_pkg::REGION_RAM)     ? req_i.wmask : 4'b0000;
    assign dsp_wmask_o = (region_o == bus_pkg::REGION_DISPLAY) ? req_i.wmask : 4'b0000;

    // A keyboard read consumes the head event
    assign kbd_pop_o = (region_o == bus_pkg::REGION_KEYBOARD) && req_i.rd;

    // At most one device may be written in a cycle
    always_comb begin
        assert (!((|ram_wmask_o) && (|dsp_wmask_o)))
        else $error("RAM and display written in the same cycle");
    end

endmodule

`default_nettype wire

//--- src/map_pkg.sv
`default_nettype none

package map_pkg;

    // Memory map
    //   1xxxxxxx   RAM
    //   FF000000   seven segment display register
    //   FF000004   switch bank
    //   FF000008   keyboard event FIFO
    //   all else   unmapped, reads give zero
    localparam logic [3:0]     RAM_NIBBLE = 4'h1;
    localparam bus_pkg::word_t DSP_ADDR   = 32'hFF00_0000;
    localparam bus_pkg::word_t SW_ADDR    = 32'hFF00_0004;
    localparam bus_pkg::word_t KBD_ADDR   = 32'hFF00_0008;

    // Cycles each digit stays lit
    localparam int DSP_DIVISOR = 16;
    localparam int DSP_DIV_W   = $clog2(DSP_DIVISOR);
    localparam logic [DSP_DIV_W-1:0] DSP_LAST = DSP_DIV_W'(DSP_DIVISOR - 1);

    // Cathode patterns, bit order dp g f e d c b a, active low
    localparam logic [0:15][7:0] SEG_CODES = {
        8'hC0, 8'hF9, 8'hA4, 8'hB0,
        8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    // Blank digit
    localparam logic [7:0] SEG_OFF = 8'hFF;

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Stretch length of the internal reset after the external one drops
    localparam int RESET_CYCLES = 12;

    // RAM sizing, word index taken from address bits 11:2
    localparam int RAM_WORDS  = 1024;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    // Keyboard FIFO sizing, depth doubles as the producer's starting credit
    localparam int KBD_DEPTH = 8;
    localparam int KBD_PTR_W = $clog2(KBD_DEPTH);
    localparam int KBD_CNT_W = $clog2(KBD_DEPTH + 1);
    localparam logic [KBD_CNT_W-1:0] KBD_FULL = KBD_CNT_W'(KBD_DEPTH);

    typedef logic [31:0] word_t;

    // One data memory access, 69 bits
    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] wmask;
        logic       rd;
    } dmem_req_t;

    // Decoded key event from the keyboard side
    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } kbd_event_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_DISPLAY,
        REGION_SWITCH,
        REGION_KEYBOARD
    } region_t;

endpackage

`default_nettype wire
